// ==== hw/gprPkg.sv ====
package gprPkg;

	localparam int regWidth = 64;
	localparam int addrWidth = 48;
	localparam int immWidth = 33;                 // Decoded immediate incl. sign bit

	typedef logic [5:0] regId;

	// Special register numbers above the GPR range
	localparam regId regDlr = 6'h20;
	localparam regId regDhr = 6'h21;
	localparam regId regSp  = 6'h22;
	localparam regId regPc  = 6'h24;
	localparam regId regGbr = 6'h25;
	localparam regId regLr  = 6'h26;
	localparam regId regImm = 6'h3E;              // Immediate pseudo-register
	localparam regId regZzr = 6'h3F;              // Always reads zero

	typedef struct packed
	{
		logic valid;
		regId id;                                 // Destination register
		logic [regWidth-1:0] value;
	} wbPort;

endpackage

// ==== hw/opPkg.sv ====
package opPkg;

	// Extra held cycles of a multiply
	localparam int unsigned mulWaitCycles = 3;

	typedef enum logic [5:0]
	{
		opAdd   = 6'h01,
		opSub   = 6'h02,
		opAnd   = 6'h03,
		opOr    = 6'h04,
		opXor   = 6'h05,
		opMov   = 6'h06,                          // Rn = Rs
		opAddi  = 6'h10,                          // Rn = Rs + imm
		opSpAdj = 6'h11,                          // SP = SP + imm
		opMul   = 6'h20                           // DHR:DLR = Rs * Rt
	} opCode;

	typedef struct packed
	{
		opCode op;
		gprPkg::regId rn;
		gprPkg::regId rs;
		gprPkg::regId rt;
		logic [7:0] pad;
	} regFormT;

	typedef struct packed
	{
		opCode op;
		gprPkg::regId rn;
		gprPkg::regId rs;
		logic signed [13:0] imm;
	} immFormT;

	// Opcode selects the view
	typedef union packed
	{
		regFormT regForm;
		immFormT immForm;
	} instrWord;

	typedef struct packed
	{
		logic valid;
		opCode op;
		gprPkg::regId rn;
		logic [gprPkg::regWidth-1:0] opA;
		logic [gprPkg::regWidth-1:0] opB;
	} stageReg;

endpackage

// ==== hw/regGpr.sv ====
module regGpr
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input gprPkg::regId idA,
	input gprPkg::regId idB,
	input logic [gprPkg::immWidth-1:0] regValImm,
	input logic [gprPkg::addrWidth-1:0] pc,
	input logic [gprPkg::addrWidth-1:0] gbr,
	input logic [gprPkg::addrWidth-1:0] lr,
	input gprPkg::wbPort ex1,
	input gprPkg::wbPort ex2,
	input logic [gprPkg::regWidth-1:0] dlrNext,
	input logic [gprPkg::regWidth-1:0] dhrNext,
	input logic [gprPkg::regWidth-1:0] spNext,
	output logic [gprPkg::regWidth-1:0] valA,
	output logic [gprPkg::regWidth-1:0] valB,
	output logic [gprPkg::regWidth-1:0] dlr,
	output logic [gprPkg::regWidth-1:0] dhr,
	output logic [gprPkg::regWidth-1:0] sp
);
	import gprPkg::*;

	logic [regWidth-1:0] gprArr [32];

	// One read port, decode then forward
	function automatic logic [regWidth-1:0] readPort(regId id);
		logic [regWidth-1:0] value;
		logic canBypass;

		canBypass = 1'b1;
		case (id) inside
			6'b0?????: value = gprArr[id[4:0]];
			regDlr:    value = dlrNext;           // Finished multiply shows at once
			regDhr:    value = dhrNext;
			regSp:     value = spNext;
			regPc:
			begin
				value = regWidth'(pc);            // Zero-extended
				canBypass = 1'b0;
			end
			regGbr:
			begin
				value = regWidth'(gbr);
				canBypass = 1'b0;
			end
			regLr:
			begin
				value = regWidth'(lr);
				canBypass = 1'b0;
			end
			regImm:
			begin
				value = {{(regWidth - immWidth){regValImm[immWidth-1]}}, regValImm};
				canBypass = 1'b0;
			end
			default:
			begin
				value = '0;                       // ZZR and unused numbers
				canBypass = 1'b0;
			end
		endcase

		// Newest result wins
		if (canBypass && ex2.valid && ex2.id == id)
			value = ex2.value;
		if (canBypass && ex1.valid && ex1.id == id)
			value = ex1.value;
		return value;
	endfunction

	always_comb
	begin
		valA = readPort(idA);
		valB = readPort(idB);
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 32; i++)
				gprArr[i] <= '0;
			dlr <= '0;
			dhr <= '0;
			sp <= '0;
		end
		else if (!hold)
		begin
			dlr <= (ex2.valid && ex2.id == regDlr) ? ex2.value : dlrNext;
			dhr <= (ex2.valid && ex2.id == regDhr) ? ex2.value : dhrNext;
			sp  <= (ex2.valid && ex2.id == regSp)  ? ex2.value : spNext;
			if (ex2.valid && !ex2.id[5])
				gprArr[ex2.id[4:0]] <= ex2.value;
		end
	end

endmodule

// ==== hw/aluPipe.sv ====
module aluPipe
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic accept,
	input opPkg::opCode op,
	input gprPkg::regId rn,
	input logic [gprPkg::regWidth-1:0] valA,
	input logic [gprPkg::regWidth-1:0] valB,
	input logic [gprPkg::regWidth-1:0] dlr,
	input logic [gprPkg::regWidth-1:0] dhr,
	input logic [gprPkg::regWidth-1:0] sp,
	output gprPkg::wbPort ex1,
	output gprPkg::wbPort ex2,
	output logic mulInEx1,
	output logic [gprPkg::regWidth-1:0] dlrNext,
	output logic [gprPkg::regWidth-1:0] dhrNext,
	output logic [gprPkg::regWidth-1:0] spNext
);
	import gprPkg::*;
	import opPkg::*;

	stageReg stage;                               // EX1 contents
	logic [regWidth-1:0] result;
	logic resultValid;
	logic [regWidth-1:0] spBase;
	logic [regWidth-1:0] mulA;
	logic [regWidth-1:0] mulB;
	logic mulPending;
	logic [2*regWidth-1:0] product;

	always_ff @(posedge clock)
	begin
		if (!rstN)
			stage.valid <= 1'b0;
		else if (!hold)
			stage <= '{valid: accept, op: op, rn: rn, opA: valA, opB: valB};
	end

	always_comb
	begin
		spBase = (ex2.valid && ex2.id == regSp) ? ex2.value : sp;   // SP write still in EX2
		resultValid = 1'b1;
		case (stage.op)
			opAdd, opAddi: result = stage.opA + stage.opB;
			opSub:   result = stage.opA - stage.opB;
			opAnd:   result = stage.opA & stage.opB;
			opOr:    result = stage.opA | stage.opB;
			opXor:   result = stage.opA ^ stage.opB;
			opMov:   result = stage.opA;
			opSpAdj: result = spBase + stage.opB;
			default:
			begin
				result = '0;                      // Multiply and unknown codes
				resultValid = 1'b0;
			end
		endcase
		ex1.valid = stage.valid && resultValid;
		ex1.id = (stage.op == opSpAdj) ? regSp : stage.rn;
		ex1.value = result;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
			ex2.valid <= 1'b0;
		else if (!hold)
			ex2 <= ex1;
	end

	assign mulInEx1 = stage.valid && stage.op == opMul;

	// Multiply operands stay put while the pipe is held
	always_ff @(posedge clock)
	begin
		if (mulInEx1 && !hold)
		begin
			mulA <= stage.opA;
			mulB <= stage.opB;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
			mulPending <= 1'b0;
		else if (!hold)
			mulPending <= mulInEx1;
	end

	assign product = mulA * mulB;                 // Multicycle path, unsigned

	assign dlrNext = mulPending ? product[regWidth-1:0] : dlr;
	assign dhrNext = mulPending ? product[2*regWidth-1:regWidth] : dhr;
	assign spNext = (stage.valid && stage.op == opSpAdj) ? result : sp;

endmodule

// ==== hw/stallTimer.sv ====
module stallTimer
(
	input logic clock,
	input logic rstN,
	input logic load,
	output logic done
);
	import opPkg::*;

	logic [$clog2(mulWaitCycles + 1)-1:0] count;

	always_ff @(posedge clock)
	begin
		if (!rstN)
			count <= '0;
		else if (load)
			count <= $bits(count)'(mulWaitCycles);
		else if (count != '0)
			count <= count - 1'b1;
	end

	// High in the last held cycle only
	assign done = (count == 1);

endmodule

// ==== hw/pipeCtrl.sv ====
module pipeCtrl
(
	input logic clock,
	input logic rstN,
	input logic mulInEx1,
	input logic done,
	output logic hold,
	output logic load
);
	typedef enum logic
	{
		run,
		mulWait
	} ctrlState;

	ctrlState state;
	ctrlState stateNext;

	always_comb
	begin
		stateNext = state;
		load = 1'b0;
		case (state)
			run:
			begin
				if (mulInEx1)
				begin
					load = 1'b1;                  // Start the wait timer
					stateNext = mulWait;
				end
			end
			mulWait:
			begin
				if (done)
					stateNext = run;
			end
			default: stateNext = run;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
			state <= run;
		else
			state <= stateNext;
	end

	assign hold = (state == mulWait);

endmodule

// ==== hw/execCore.sv ====
module execCore
(
	input logic clock,
	input logic rstN,
	input logic instValid,
	input opPkg::instrWord instr,
	input logic [gprPkg::addrWidth-1:0] pc,
	input logic [gprPkg::addrWidth-1:0] gbr,
	input logic [gprPkg::addrWidth-1:0] lr,
	output logic busy,
	output gprPkg::wbPort wb
);
	import gprPkg::*;
	import opPkg::*;

	logic hold;
	logic accept;
	logic load;
	logic done;
	logic mulInEx1;
	logic useImm;
	regId idB;
	logic [immWidth-1:0] regValImm;
	logic [regWidth-1:0] valA;
	logic [regWidth-1:0] valB;
	logic [regWidth-1:0] dlr;
	logic [regWidth-1:0] dhr;
	logic [regWidth-1:0] sp;
	logic [regWidth-1:0] dlrNext;
	logic [regWidth-1:0] dhrNext;
	logic [regWidth-1:0] spNext;
	wbPort ex1;
	wbPort ex2;

	// Immediate forms take source B from the immediate
	assign useImm = (instr.immForm.op == opAddi) || (instr.immForm.op == opSpAdj);
	assign idB = useImm ? regImm : instr.regForm.rt;
	assign regValImm = immWidth'(instr.immForm.imm);   // Sign-extends
	assign accept = instValid && !hold;
	assign busy = hold;
	assign wb = ex2;

	regGpr u_regGpr
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.idA(instr.regForm.rs),
		.idB(idB),
		.regValImm(regValImm),
		.pc(pc),
		.gbr(gbr),
		.lr(lr),
		.ex1(ex1),
		.ex2(ex2),
		.dlrNext(dlrNext),
		.dhrNext(dhrNext),
		.spNext(spNext),
		.valA(valA),
		.valB(valB),
		.dlr(dlr),
		.dhr(dhr),
		.sp(sp)
	);

	aluPipe u_aluPipe
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.accept(accept),
		.op(instr.regForm.op),
		.rn(instr.regForm.rn),
		.valA(valA),
		.valB(valB),
		.dlr(dlr),
		.dhr(dhr),
		.sp(sp),
		.ex1(ex1),
		.ex2(ex2),
		.mulInEx1(mulInEx1),
		.dlrNext(dlrNext),
		.dhrNext(dhrNext),
		.spNext(spNext)
	);

	stallTimer u_stallTimer
	(
		.clock(clock),
		.rstN(rstN),
		.load(load),
		.done(done)
	);

	pipeCtrl u_pipeCtrl
	(
		.clock(clock),
		.rstN(rstN),
		.mulInEx1(mulInEx1),
		.done(done),
		.hold(hold),
		.load(load)
	);

endmodule

// ==== bench/execCore_props.sv ====
module execCore_props
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input opPkg::stageReg stage,
	input gprPkg::wbPort ex2
);
	import opPkg::*;

	int failCount = 0;

	// Hold covers exactly the multiply wait
	holdLength: assert property (@(posedge clock) disable iff (!rstN)
		$rose(hold) |-> hold [*mulWaitCycles] ##1 !hold)
		else
		begin
			failCount++;
			$error("hold did not last exactly %0d cycles", mulWaitCycles);
		end

	mulStartsHold: assert property (@(posedge clock) disable iff (!rstN)
		stage.valid && stage.op == opMul && !hold |=> hold)
		else
		begin
			failCount++;
			$error("multiply in EX1 did not raise hold");
		end

	noWbWhileHeld: assert property (@(posedge clock) disable iff (!rstN)
		hold |-> !ex2.valid)
		else
		begin
			failCount++;
			$error("writeback valid while the pipe is held");
		end

	quietAfterReset: assert property (@(posedge clock)
		!rstN |=> !hold && !ex2.valid)
		else
		begin
			failCount++;
			$error("hold or writeback active right after reset");
		end

endmodule

// ==== bench/execCoreChecker.sv ====
module execCoreChecker
(
	input logic clock,
	input logic rstN,
	input logic instValid,
	input logic busy,
	input opPkg::instrWord instr,
	input logic [gprPkg::addrWidth-1:0] pc,
	input logic [gprPkg::addrWidth-1:0] gbr,
	input logic [gprPkg::addrWidth-1:0] lr,
	input gprPkg::wbPort wb,
	output int errors,
	output int checks,
	output int pending
);
	import gprPkg::*;
	import opPkg::*;

	logic [regWidth-1:0] gprModel [32];
	logic [regWidth-1:0] dlrModel;
	logic [regWidth-1:0] dhrModel;
	logic [regWidth-1:0] spModel;
	wbPort expQ [$];                              // Results still in flight
	wbPort expEntry;

	function automatic logic [regWidth-1:0] readModel(regId id, logic [13:0] imm);
		case (id) inside
			[6'd0:6'd31]: return gprModel[id[4:0]];
			regDlr: return dlrModel;
			regDhr: return dhrModel;
			regSp:  return spModel;
			regPc:  return regWidth'(pc);
			regGbr: return regWidth'(gbr);
			regLr:  return regWidth'(lr);
			regImm: return {{(regWidth - 14){imm[13]}}, imm};
			default: return '0;
		endcase
	endfunction

	function automatic void writeModel(regId id, logic [regWidth-1:0] value);
		if (!id[5])
			gprModel[id[4:0]] = value;
		else if (id == regDlr)
			dlrModel = value;
		else if (id == regDhr)
			dhrModel = value;
		else if (id == regSp)
			spModel = value;                      // Anything else is dropped
	endfunction

	// In-order result of one instruction, no pipeline involved
	function automatic wbPort refExec(instrWord w);
		logic [regWidth-1:0] a;
		logic [regWidth-1:0] b;
		logic [2*regWidth-1:0] prod;
		logic [13:0] imm;
		wbPort expected;

		imm = w.immForm.imm;
		a = readModel(w.regForm.rs, imm);
		if (w.immForm.op == opAddi || w.immForm.op == opSpAdj)
			b = {{(regWidth - 14){imm[13]}}, imm};
		else
			b = readModel(w.regForm.rt, imm);
		expected.valid = 1'b1;
		expected.id = w.regForm.rn;
		case (w.regForm.op)
			opAdd, opAddi: expected.value = a + b;
			opSub: expected.value = a - b;
			opAnd: expected.value = a & b;
			opOr:  expected.value = a | b;
			opXor: expected.value = a ^ b;
			opMov: expected.value = a;
			opSpAdj:
			begin
				expected.id = regSp;
				expected.value = spModel + b;
			end
			opMul:
			begin
				prod = {{regWidth{1'b0}}, a} * {{regWidth{1'b0}}, b};
				dlrModel = prod[regWidth-1:0];
				dhrModel = prod[2*regWidth-1:regWidth];
				expected = '0;                    // No GPR writeback
			end
			default: expected = '0;
		endcase
		if (expected.valid)
			writeModel(expected.id, expected.value);
		return expected;
	endfunction

	always @(posedge clock)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 32; i++)
				gprModel[i] = '0;
			dlrModel = '0;
			dhrModel = '0;
			spModel = '0;
			expQ.delete();
			errors = 0;
			checks = 0;
		end
		else
		begin
			if (wb.valid)
			begin
				if (expQ.size() == 0)
				begin
					errors++;
					$display("Unexpected writeback at %0t with nothing outstanding", $time);
				end
				else
				begin
					expEntry = expQ.pop_front();
					checks++;
					if (wb.id !== expEntry.id)
					begin
						errors++;
						$display("FAIL at %0t: wb.id expected %h actual %h",
							$time, expEntry.id, wb.id);
					end
					if (wb.value !== expEntry.value)
					begin
						errors++;
						$display("FAIL at %0t: wb.value expected %h actual %h",
							$time, expEntry.value, wb.value);
					end
				end
			end
			if (instValid && !busy)              // Same rule as the DUT's accept
			begin
				expEntry = refExec(instr);
				if (expEntry.valid)
					expQ.push_back(expEntry);
			end
		end
		pending = expQ.size();
	end

endmodule

// ==== bench/execCoreTb.sv ====
module execCoreTb;
	import gprPkg::*;
	import opPkg::*;

	localparam int numDirected = 74;
	localparam int numRandom = 300;
	localparam int timeoutLimit = (numDirected + numRandom) * (3 + mulWaitCycles) + 16 + 50;

	logic clock = 1'b0;
	logic rstN;
	logic instValid;
	instrWord instr;
	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] gbr;
	logic [addrWidth-1:0] lr;
	logic busy;
	wbPort wb;
	int checkErrors;
	int checkCount;
	int pending;
	int timeoutErrors = 0;
	int cycleCount = 0;
	logic [31:0] rngState;
	bit offerWhileBusy;                           // Offer junk during a multiply wait

	always #10 clock = ~clock;

	execCore u_dut
	(
		.clock(clock),
		.rstN(rstN),
		.instValid(instValid),
		.instr(instr),
		.pc(pc),
		.gbr(gbr),
		.lr(lr),
		.busy(busy),
		.wb(wb)
	);

	execCoreChecker u_checker
	(
		.clock(clock),
		.rstN(rstN),
		.instValid(instValid),
		.busy(busy),
		.instr(instr),
		.pc(pc),
		.gbr(gbr),
		.lr(lr),
		.wb(wb),
		.errors(checkErrors),
		.checks(checkCount),
		.pending(pending)
	);

	bind aluPipe execCore_props u_props
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.stage(stage),
		.ex2(ex2)
	);

	function automatic instrWord regInstr(opCode op, regId rn, regId rs, regId rt);
		instrWord w;

		w.regForm = '{op, rn, rs, rt, 8'h00};
		return w;
	endfunction

	function automatic instrWord immInstr(opCode op, regId rn, regId rs, int imm);
		instrWord w;

		w.immForm = '{op, rn, rs, imm[13:0]};
		return w;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1103515245 + 32'd12345;
		return rngState >> 8;                     // Low bits of an LCG are weak
	endfunction

	function automatic regId randReg();
		regId specials [8];
		logic [31:0] r;

		specials = '{regDlr, regDhr, regSp, regPc, regGbr, regLr, regZzr, regSp};
		r = nextRand();
		if (r % 4 != 0)
			return regId'(r[12:8]);               // Mostly GPRs
		return specials[r[18:16]];
	endfunction

	function automatic instrWord randInstr();
		opCode opList [9];
		opCode op;
		regId rn;
		regId rs;
		regId rt;
		logic [31:0] r;

		opList = '{opAdd, opSub, opAnd, opOr, opXor, opMov, opAddi, opSpAdj, opMul};
		r = nextRand();
		op = opList[r % 9];
		rn = randReg();
		rs = randReg();
		rt = randReg();
		r = nextRand();
		if (op == opAddi || op == opSpAdj)
			return immInstr(op, rn, rs, int'(r));
		return regInstr(op, rn, rs, rt);
	endfunction

	// Waits for a free slot, then offers one instruction
	task automatic sendInstr(input instrWord w);
		do
			@(negedge clock);
		while (busy);
		@(posedge clock);
		instValid <= 1'b1;
		instr <= w;
		if (w.regForm.op == opMul)
		begin
			@(posedge clock);                     // Multiply taken here
			instValid <= 1'b0;
			@(posedge clock);                     // Hold rises here
			if (offerWhileBusy)
			begin
				repeat (mulWaitCycles)
				begin
					instValid <= 1'b1;
					instr <= regInstr(opAdd, 1, 1, 1);
					@(posedge clock);
				end
				instValid <= 1'b0;
			end
		end
	endtask

	task automatic printSummary();
		$display("Checks %0d, checker errors %0d, assertion failures %0d, timeouts %0d",
			checkCount, checkErrors, u_dut.u_aluPipe.u_props.failCount, timeoutErrors);
	endtask

	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount >= timeoutLimit)
		begin
			timeoutErrors++;
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycleCount);
			printSummary();
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		rstN = 1'b0;
		instValid = 1'b0;
		instr = '0;
		pc = 48'h8000_1234_5678;
		gbr = 48'hFFFF_0000_0010;                 // Top bit set, must not sign-extend
		lr = 48'h0000_ABCD_EF00;
		offerWhileBusy = 1'b0;
		rngState = 32'd12;
		repeat (16) @(posedge clock);
		rstN <= 1'b1;

		// Everything reads zero after reset
		for (int i = 0; i < 32; i++)
			sendInstr(regInstr(opMov, regZzr, regId'(i), regZzr));
		sendInstr(regInstr(opMov, regZzr, regDlr, regZzr));
		sendInstr(regInstr(opMov, regZzr, regDhr, regZzr));
		sendInstr(regInstr(opMov, regZzr, regSp, regZzr));

		sendInstr(immInstr(opAddi, 1, regZzr, 100));
		sendInstr(immInstr(opAddi, 2, regZzr, -5));
		sendInstr(immInstr(opAddi, 3, regZzr, -8192));
		sendInstr(immInstr(opAddi, 4, regZzr, 8191));
		sendInstr(regInstr(opAdd, 5, 1, 2));
		sendInstr(regInstr(opSub, 6, 2, 1));
		sendInstr(regInstr(opAnd, 7, 3, 4));
		sendInstr(regInstr(opOr, 8, 2, 4));
		sendInstr(regInstr(opXor, 9, 3, 1));
		sendInstr(regInstr(opMov, 10, 3, regZzr));

		// Dependencies at distance one, two and three
		sendInstr(immInstr(opAddi, 11, 1, 1));
		sendInstr(regInstr(opAdd, 12, 11, 11));
		sendInstr(immInstr(opAddi, 13, regZzr, 7));
		sendInstr(immInstr(opAddi, 19, regZzr, 1));
		sendInstr(regInstr(opAdd, 14, 13, 13));
		sendInstr(immInstr(opAddi, 15, regZzr, 9));
		sendInstr(immInstr(opAddi, 19, 19, 1));
		sendInstr(immInstr(opAddi, 19, 19, 1));
		sendInstr(regInstr(opAdd, 16, 15, 15));
		sendInstr(immInstr(opAddi, 16, 16, 1));
		sendInstr(regInstr(opAdd, 17, 16, 16));   // EX1 and EX2 both hold r16

		sendInstr(immInstr(opAddi, 21, regZzr, -1));
		offerWhileBusy = 1'b1;
		sendInstr(regInstr(opMul, regZzr, 21, 21));
		offerWhileBusy = 1'b0;
		sendInstr(regInstr(opMov, 23, regDlr, regZzr));
		sendInstr(regInstr(opMov, 24, regDhr, regZzr));
		sendInstr(regInstr(opMul, regZzr, 1, 2));
		sendInstr(regInstr(opMov, 25, regDlr, regZzr));
		sendInstr(regInstr(opMov, 26, regDhr, regZzr));

		sendInstr(regInstr(opMov, 27, regPc, regZzr));
		sendInstr(regInstr(opMov, 28, regGbr, regZzr));
		sendInstr(regInstr(opMov, 29, regLr, regZzr));
		sendInstr(regInstr(opMov, regZzr, 1, regZzr));
		sendInstr(regInstr(opMov, 30, regZzr, regZzr));
		sendInstr(regInstr(opMov, regPc, 1, regZzr));
		sendInstr(regInstr(opMov, 27, regPc, regZzr));
		sendInstr(immInstr(opSpAdj, regSp, regZzr, -16));
		sendInstr(immInstr(opSpAdj, regSp, regZzr, 40));
		sendInstr(regInstr(opMov, 31, regSp, regZzr));
		sendInstr(regInstr(opAdd, 30, regSp, 1));

		repeat (numRandom)
			sendInstr(randInstr());
		@(posedge clock);
		instValid <= 1'b0;

		do
			@(negedge clock);
		while (pending != 0);
		repeat (4) @(negedge clock);              // Catch stray writebacks

		printSummary();
		if (checkErrors + u_dut.u_aluPipe.u_props.failCount + timeoutErrors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
hw/gprPkg.sv
hw/opPkg.sv
hw/regGpr.sv
hw/aluPipe.sv
hw/stallTimer.sv
hw/pipeCtrl.sv
hw/execCore.sv
bench/execCore_props.sv
bench/execCoreChecker.sv
bench/execCoreTb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - hw/gprPkg.sv
  - hw/opPkg.sv
  - hw/regGpr.sv
  - hw/aluPipe.sv
  - hw/stallTimer.sv
  - hw/pipeCtrl.sv
  - hw/execCore.sv
  - target: test
    files:
      - bench/execCore_props.sv
      - bench/execCoreChecker.sv
      - bench/execCoreTb.sv
